// File: compile.f
+incdir+logic
logic/aluPkg.sv
logic/aluOpIngress.sv
logic/aluCore.sv
logic/aluResultEgress.sv
logic/aluExecUnit.sv
verification/aluExecUnitTb.sv

// File: logic/aluConsts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define ALU_DATA_WIDTH 64 // operand and result width.
`define ALU_OP_WIDTH 5
`define ALU_TAG_WIDTH 4

// input FIFO depth doubles as the producer's starting credit count.
`define ALU_IN_DEPTH 4
`define ALU_OUT_DEPTH 4

`define ALU_CREDIT_WIDTH 3 // holds 0 up to either depth.

`endif

// File: logic/aluCore.sv
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluCore (
    input  logic              clock,
    input  logic              reset,
    input  logic              issueValid,
    input  aluPkg::aluRequest issueRequest,
    output logic              coreValid,
    output aluPkg::aluResult  coreResult
);

    localparam int Msb = `ALU_DATA_WIDTH - 1;
    localparam int HalfWidth = `ALU_DATA_WIDTH / 2;
    localparam int ShiftWidth = $clog2(`ALU_DATA_WIDTH);

    aluPkg::aluOp op;
    aluPkg::aluData opA;
    aluPkg::aluData opB;

    logic subCtrl;
    logic arithCtrl;
    logic signedCtrl;
    logic wordCtrl;

    aluPkg::aluData opBAdj;
    aluPkg::aluData sum;
    logic carryLow;
    logic carryOut;
    logic carryFlag;
    logic signFlag;
    logic overflowFlag;
    logic zeroFlag;

    logic [ShiftWidth-1:0] shiftAmount;
    aluPkg::aluData rightSrc;
    aluPkg::aluData rawValue;
    aluPkg::aluData finalValue;
    logic wordFunc;

    aluPkg::aluResult resultQ;
    logic validQ;

    assign op = issueRequest.op;
    assign opA = issueRequest.a;
    assign opB = issueRequest.b;

    // decode.
    assign subCtrl = op[3] | op[1]; // slt needs the difference too.
    assign arithCtrl = op[3];
    assign signedCtrl = op[3];
    assign wordCtrl = op[4];

    // adder, top bit split off for the overflow carry.
    assign opBAdj = subCtrl ? ~opB : opB;
    assign {carryLow, sum[Msb-1:0]} = {1'b0, opA[Msb-1:0]} + {1'b0, opBAdj[Msb-1:0]}
                                      + aluPkg::aluData'(subCtrl);
    assign {carryOut, sum[Msb]} = {1'b0, opA[Msb]} + {1'b0, opBAdj[Msb]} + {1'b0, carryLow};

    assign carryFlag = subCtrl ^ carryOut; // borrow when subtracting.
    assign signFlag = sum[Msb];
    assign overflowFlag = carryOut ^ carryLow;
    assign zeroFlag = ~(|sum);

    // word shifts only see five bits of b.
    assign shiftAmount = wordCtrl ? {1'b0, opB[ShiftWidth-2:0]} : opB[ShiftWidth-1:0];
    assign rightSrc = wordCtrl ? {{HalfWidth{opA[HalfWidth-1] & arithCtrl}}, opA[HalfWidth-1:0]}
                               : opA;

    always_comb begin
        case (op[2:0])
            3'd0: rawValue = sum;
            3'd1: rawValue = opA << shiftAmount;
            3'd2: rawValue = aluPkg::aluData'(signedCtrl ? (overflowFlag ^ signFlag) : carryFlag);
            3'd3: rawValue = opB;
            3'd4: rawValue = opA ^ opB;
            3'd5: begin
                if (arithCtrl) begin
                    rawValue = $signed(rightSrc) >>> shiftAmount;
                end else begin
                    rawValue = rightSrc >> shiftAmount;
                end
            end
            3'd6: rawValue = opA | opB;
            default: rawValue = opA & opB;
        endcase
    end

    // word form applies to add, sub and the shifts only.
    assign wordFunc = wordCtrl && (op[2:0] == 3'd0 || op[2:0] == 3'd1 || op[2:0] == 3'd5);
    assign finalValue = wordFunc ? {{HalfWidth{rawValue[HalfWidth-1]}}, rawValue[HalfWidth-1:0]}
                                 : rawValue;

    always_ff @(posedge clock) begin
        if (reset) begin
            validQ <= 1'b0;
        end else begin
            validQ <= issueValid;
        end
    end

    always_ff @(posedge clock) begin
        if (issueValid) begin
            resultQ.value <= finalValue;
            resultQ.zero <= zeroFlag;
            resultQ.tag <= issueRequest.tag;
        end
    end

    assign coreValid = validQ;
    assign coreResult = resultQ;

    assert property (@(posedge clock) reset |=> !coreValid)
        else $error("core result valid right after reset");

endmodule

// File: logic/aluExecUnit.sv
`timescale 1ns/1ps

module aluExecUnit (
    input  logic              clock,
    input  logic              reset,
    input  logic              requestValid,
    input  aluPkg::aluRequest request,
    output logic              requestCredit,
    output logic              resultValid,
    output aluPkg::aluResult  result,
    input  logic              resultCredit
);

    logic issueAllow;
    logic issueValid;
    aluPkg::aluRequest issueRequest;
    logic coreValid;
    aluPkg::aluResult coreResult;

    aluOpIngress i_aluOpIngress (
        .clock         (clock),
        .reset         (reset),
        .requestValid  (requestValid),
        .request       (request),
        .requestCredit (requestCredit),
        .issueAllow    (issueAllow),
        .issueValid    (issueValid),
        .issueRequest  (issueRequest)
    );

    aluCore i_aluCore (
        .clock        (clock),
        .reset        (reset),
        .issueValid   (issueValid),
        .issueRequest (issueRequest),
        .coreValid    (coreValid),
        .coreResult   (coreResult)
    );

    aluResultEgress i_aluResultEgress (
        .clock        (clock),
        .reset        (reset),
        .coreValid    (coreValid),
        .coreResult   (coreResult),
        .issueValid   (issueValid),
        .issueAllow   (issueAllow),
        .resultValid  (resultValid),
        .result       (result),
        .resultCredit (resultCredit)
    );

endmodule

// File: logic/aluOpIngress.sv
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluOpIngress (
    input  logic              clock,
    input  logic              reset,
    input  logic              requestValid,
    input  aluPkg::aluRequest request,
    output logic              requestCredit,
    input  logic              issueAllow,
    output logic              issueValid,
    output aluPkg::aluRequest issueRequest
);

    localparam int PtrWidth = $clog2(`ALU_IN_DEPTH);
    localparam int LastSlot = `ALU_IN_DEPTH - 1;

    aluPkg::aluRequest fifoMem [`ALU_IN_DEPTH];
    logic [PtrWidth-1:0] writePtr;
    logic [PtrWidth-1:0] readPtr;
    aluPkg::aluCredit fillCount;
    logic fifoEmpty;
    logic fifoFull;

    assign fifoEmpty = (fillCount == '0);
    assign fifoFull = (fillCount == aluPkg::aluCredit'(`ALU_IN_DEPTH));

    assign issueValid = !fifoEmpty && issueAllow;
    assign issueRequest = fifoMem[readPtr];
    assign requestCredit = issueValid; // freed slot goes back upstream.

    always_ff @(posedge clock) begin
        if (reset) begin
            writePtr <= '0;
            readPtr <= '0;
            fillCount <= '0;
        end else begin
            if (requestValid) begin
                writePtr <= (writePtr == PtrWidth'(LastSlot)) ? '0 : writePtr + 1'b1;
            end
            if (issueValid) begin
                readPtr <= (readPtr == PtrWidth'(LastSlot)) ? '0 : readPtr + 1'b1;
            end
            fillCount <= fillCount + aluPkg::aluCredit'(requestValid)
                         - aluPkg::aluCredit'(issueValid);
        end
    end

    always_ff @(posedge clock) begin
        if (requestValid) begin
            fifoMem[writePtr] <= request;
        end
    end

    // a write into a full FIFO means the producer spent a credit it never got.
    assert property (@(posedge clock) disable iff (reset)
        requestValid |-> !fifoFull)
        else $error("request written into full input FIFO");

endmodule

// File: logic/aluPkg.sv
`include "aluConsts.svh"

package aluPkg;

    typedef logic [`ALU_DATA_WIDTH-1:0] aluData;
    typedef logic [`ALU_TAG_WIDTH-1:0] aluTag;
    typedef logic [`ALU_CREDIT_WIDTH-1:0] aluCredit;

    // bits 2..0 function, bit 3 alternate form, bit 4 word form.
    typedef logic [`ALU_OP_WIDTH-1:0] aluOp;

    typedef struct packed {
        aluOp   op;
        aluData a;
        aluData b;
        aluTag  tag;
    } aluRequest;

    typedef struct packed {
        aluData value;
        logic   zero; // from the full-width adder sum.
        aluTag  tag;
    } aluResult;

endpackage

// File: logic/aluResultEgress.sv
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluResultEgress (
    input  logic             clock,
    input  logic             reset,
    input  logic             coreValid,
    input  aluPkg::aluResult coreResult,
    input  logic             issueValid,
    output logic             issueAllow,
    output logic             resultValid,
    output aluPkg::aluResult result,
    input  logic             resultCredit
);

    localparam int PtrWidth = $clog2(`ALU_OUT_DEPTH);
    localparam int LastSlot = `ALU_OUT_DEPTH - 1;

    aluPkg::aluResult fifoMem [`ALU_OUT_DEPTH];
    logic [PtrWidth-1:0] writePtr;
    logic [PtrWidth-1:0] readPtr;
    aluPkg::aluCredit fillCount;
    aluPkg::aluCredit creditCount;
    logic fifoEmpty;
    logic fifoFull;

    assign fifoEmpty = (fillCount == '0);
    assign fifoFull = (fillCount == aluPkg::aluCredit'(`ALU_OUT_DEPTH));

    // reserve a slot for the result still in the core.
    assign issueAllow = (fillCount + aluPkg::aluCredit'(coreValid))
                        < aluPkg::aluCredit'(`ALU_OUT_DEPTH);

    assign resultValid = !fifoEmpty && (creditCount != '0);
    assign result = fifoMem[readPtr];

    always_ff @(posedge clock) begin
        if (reset) begin
            writePtr <= '0;
            readPtr <= '0;
            fillCount <= '0;
            creditCount <= aluPkg::aluCredit'(`ALU_OUT_DEPTH);
        end else begin
            if (coreValid) begin
                writePtr <= (writePtr == PtrWidth'(LastSlot)) ? '0 : writePtr + 1'b1;
            end
            if (resultValid) begin
                readPtr <= (readPtr == PtrWidth'(LastSlot)) ? '0 : readPtr + 1'b1;
            end
            fillCount <= fillCount + aluPkg::aluCredit'(coreValid)
                         - aluPkg::aluCredit'(resultValid);
            creditCount <= creditCount + aluPkg::aluCredit'(resultCredit)
                           - aluPkg::aluCredit'(resultValid);
        end
    end

    always_ff @(posedge clock) begin
        if (coreValid) begin
            fifoMem[writePtr] <= coreResult;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        creditCount <= aluPkg::aluCredit'(`ALU_OUT_DEPTH))
        else $error("consumer returned more credits than it was given");

    assert property (@(posedge clock) disable iff (reset)
        coreValid |-> !fifoFull)
        else $error("core result arrived at full result FIFO");

    // an issue now lands here two edges later, so its slot must still be free.
    assert property (@(posedge clock) disable iff (reset)
        issueValid |=> !fifoFull)
        else $error("request issued without result space");

endmodule

// File: runSim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aluExecUnitTb \
    -f compile.f -o simv > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1

grep -q "^Result: PASSED$" sim.log \
    && { echo "simulation passed, see sim.log"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: verification/aluExecUnitTb.sv
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluExecUnitTb;

    localparam int NumVectors = 23;
    localparam int VecWords = NumVectors * 5; // op, a, b, value, zero.

    logic clock;
    logic reset;
    logic requestValid;
    aluPkg::aluRequest request;
    logic requestCredit;
    logic resultValid;
    aluPkg::aluResult result;
    logic resultCredit = 1'b0;

    aluPkg::aluData vecMem [0:VecWords-1];
    logic [15:0] lfsrState = 16'd33;
    int cycleCount = 0;
    int requestCycle = 0;
    int requestsSeen = 0;
    int creditsSpent = 0;
    int creditsReceived = 0;
    int resultsSeen = 0;
    int creditsReturned = 0;
    int returnsAccepted = 0;
    int waitLeft = 0;

    aluExecUnit i_aluExecUnit (
        .clock         (clock),
        .reset         (reset),
        .requestValid  (requestValid),
        .request       (request),
        .requestCredit (requestCredit),
        .resultValid   (resultValid),
        .result        (result),
        .resultCredit  (resultCredit)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    function automatic int creditsHeld();
        return `ALU_IN_DEPTH + creditsReceived - creditsSpent;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareData(input string name, input aluPkg::aluData got,
                               input aluPkg::aluData expected);
        if (got !== expected) begin
            failRun($sformatf("Mismatch %s: got %h expected %h (vector %0d)",
                              name, got, expected, resultsSeen));
        end
    endtask

    task automatic compareZero(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            failRun($sformatf("Mismatch %s: got %h expected %h (vector %0d)",
                              name, got, expected, resultsSeen));
        end
    endtask

    task automatic compareTag(input string name, input aluPkg::aluTag got,
                              input aluPkg::aluTag expected);
        if (got !== expected) begin
            failRun($sformatf("Mismatch %s: got %h expected %h (vector %0d)",
                              name, got, expected, resultsSeen));
        end
    endtask

    task automatic sendVector(input int idx);
        @(negedge clock);
        while (creditsHeld() == 0) begin
            requestValid = 1'b0; // out of credits, wait.
            @(negedge clock);
        end
        requestValid = 1'b1;
        request.op = aluPkg::aluOp'(vecMem[idx*5]);
        request.a = vecMem[idx*5+1];
        request.b = vecMem[idx*5+2];
        request.tag = aluPkg::aluTag'(idx);
        creditsSpent++;
    endtask

    task automatic idleProducer();
        @(negedge clock);
        requestValid = 1'b0;
    endtask

    always @(posedge clock) begin : resultMonitor
        int base;
        if (!reset) begin
            cycleCount++;
            if (requestCredit) begin
                if (creditsReceived >= requestsSeen) begin
                    failRun("producer got a credit with no request outstanding");
                end
                creditsReceived++;
            end
            if (requestValid) begin
                if (requestsSeen == 0) begin
                    requestCycle = cycleCount;
                end
                requestsSeen++;
            end
            if (resultValid) begin
                if (resultsSeen >= NumVectors) begin
                    failRun("extra result arrived after all vectors were answered");
                end
                if (resultsSeen >= `ALU_OUT_DEPTH + returnsAccepted) begin
                    failRun("result sent without a consumer credit");
                end
                base = resultsSeen * 5;
                compareData("result.value", result.value, vecMem[base+3]);
                compareZero("result.zero", result.zero, vecMem[base+4][0]);
                compareTag("result.tag", result.tag, aluPkg::aluTag'(resultsSeen));
                if (resultsSeen == 0 && cycleCount - requestCycle != 3) begin
                    failRun($sformatf("first result took %0d cycles instead of 3",
                                      cycleCount - requestCycle));
                end
                resultsSeen++;
            end
            if (resultCredit) begin
                returnsAccepted++;
            end
        end
    end

    // consumer hands back one credit per result after a random wait.
    always @(negedge clock) begin : consumerModel
        resultCredit = 1'b0;
        if (!reset && resultsSeen > creditsReturned) begin
            if (waitLeft == 0) begin
                resultCredit = 1'b1;
                creditsReturned++;
                drawBits(3, waitLeft);
            end else begin
                waitLeft--;
            end
        end
    end

    initial begin : watchdog
        repeat (NumVectors * 40 + 100) @(posedge clock);
        failRun("timeout, not all results came back in time");
    end

    initial begin : mainSequence
        reset = 1'b1;
        requestValid = 1'b0;
        request = '0;
        vecMem[VecWords-1] = '1; // last zero flag is only ever 0 or 1.
        $readmemh("verification/aluInput.txt", vecMem);
        if (vecMem[VecWords-1] === '1) begin
            failRun("could not read all vectors from verification/aluInput.txt");
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        sendVector(0); // lone request, checked for latency.
        idleProducer();
        while (resultsSeen < 1) begin
            @(negedge clock);
        end

        for (int idx = 1; idx < NumVectors; idx++) begin
            sendVector(idx);
        end
        idleProducer();

        while (resultsSeen < NumVectors || creditsReceived < NumVectors) begin
            @(negedge clock);
        end
        repeat (10) @(negedge clock); // catches stray results.
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verification/aluInput.txt
// columns: op, a, b, expected value, expected zero flag (all hex)
// zero flag follows the full 64-bit adder sum of the op's add or subtract
00 0000000000000005 0000000000000003 0000000000000008 0
00 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 1
00 7FFFFFFFFFFFFFFF 0000000000000001 8000000000000000 0
08 0000000000000010 0000000000000010 0000000000000000 1
08 8000000000000000 0000000000000001 7FFFFFFFFFFFFFFF 0
10 000000007FFFFFFF 0000000000000001 FFFFFFFF80000000 0
10 00000000FFFFFFFF 0000000000000001 0000000000000000 0
18 0000000100000005 0000000000000005 0000000000000000 0
01 0000000000000001 0000000000000000 0000000000000001 0
01 0000000000000001 000000000000003F 8000000000000000 0
05 8000000000000000 0000000000000020 0000000080000000 0
0D 8000000000000000 000000000000003F FFFFFFFFFFFFFFFF 0
11 0000000000000001 000000000000001F FFFFFFFF80000000 0
15 FFFFFFFF80000000 000000000000001F 0000000000000001 0
1D 0000000080000000 0000000000000020 FFFFFFFF80000000 0
0A FFFFFFFFFFFFFFFF 0000000000000001 0000000000000001 0
0A 8000000000000000 0000000000000001 0000000000000001 0
02 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 0
02 0000000000000005 0000000000000005 0000000000000000 1
04 0000000000000001 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE 1
06 00000000000000F0 000000000000000F 00000000000000FF 0
07 FF00FF00FF00FF00 0FF00FF00FF00FF0 0F000F000F000F00 0
03 0000000000001234 0000000000001234 0000000000001234 1
